//--- src/blend_cfg.svh
// Alpha blender build parameters
// Address width and frame-buffer read latency
`ifndef BLEND_CFG_SVH
`define BLEND_CFG_SVH

// Pixel number width, enough for 640 by 480
`define BLEND_ADDR_W 19

// Cycles from a sampled read strobe to valid read data
`define BLEND_READ_LATENCY 1

`endif

//--- src/pixel_pkg.sv
// Pixel colour types
// Channels, colour words and weighted channel sums used by every stage
`default_nettype none

package pixel_pkg;

	// One 8-bit colour channel
	typedef logic [7:0] channel_t;

	typedef struct packed {
		channel_t r;
		channel_t g;
		channel_t b;
	} rgb_t;

	// Colour plus coverage
	typedef struct packed {
		rgb_t     rgb;
		channel_t a;
	} rgba_t;

	// Weighted sum of one channel, at most 255 * 255
	typedef logic [15:0] wsum_t;

	typedef struct packed {
		wsum_t r;
		wsum_t g;
		wsum_t b;
	} wsum_rgb_t;

endpackage

`default_nettype wire

//--- src/frame_pkg.sv
// Frame-buffer types
// Pixel address and the tag that travels with each pipeline slot
`default_nettype none

`include "blend_cfg.svh"

package frame_pkg;

	typedef logic [`BLEND_ADDR_W-1:0] pix_addr_t;

	// Slot marker, a pixel and a frame end may share one slot
	typedef struct packed {
		logic      valid;
		logic      eof;
		pix_addr_t addr;
	} pix_tag_t;

endpackage

`default_nettype wire

//--- src/fetch_if.sv
// Fetch to multiply-accumulate link
// Slot tag with the foreground pixel and its background colour
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;

	frame_pkg::pix_tag_t tag;
	pixel_pkg::rgba_t    fg;
	pixel_pkg::rgb_t     bg;

	// Driven by the fetch stage
	modport src (
		output tag,
		output fg,
		output bg
	);

	// Read by the multiply-accumulate stage
	modport dst (
		input tag,
		input fg,
		input bg
	);

endinterface

`default_nettype wire

//--- src/accum_if.sv
// Multiply-accumulate to writeback link
// Slot tag with the three weighted channel sums
`timescale 1ns/1ps
`default_nettype none

interface accum_if;

	frame_pkg::pix_tag_t  tag;
	pixel_pkg::wsum_rgb_t sum;

	modport src (
		output tag,
		output sum
	);

	modport dst (
		input tag,
		input sum
	);

endinterface

`default_nettype wire

//--- src/pixel_fetch.sv
// Pixel fetch stage
// Captures foreground pixels, issues background reads and joins the returned
// background to each slot once the read latency has passed
`timescale 1ns/1ps
`default_nettype none

`include "blend_cfg.svh"

module pixel_fetch (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                pixel_ready,
	input  frame_pkg::pix_addr_t pixel_number,
	input  pixel_pkg::rgba_t    fg,
	input  logic                frame_ready,
	output logic                read,
	output frame_pkg::pix_addr_t read_addr,
	input  pixel_pkg::rgb_t     read_data,
	fetch_if.src                out
);

	localparam int L = `BLEND_READ_LATENCY;

	// Delay line covering the outstanding read, stage 0 is the capture register
	frame_pkg::pix_tag_t tag_q [0:L];
	pixel_pkg::rgba_t    fg_q  [0:L];

	// Capture stage doubles as the read request
	assign read      = tag_q[0].valid;
	assign read_addr = tag_q[0].addr;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i <= L; i++)
			begin
				tag_q[i] <= '0;
			end
		end
		else
		begin
			tag_q[0].valid <= pixel_ready;
			tag_q[0].eof   <= frame_ready;
			tag_q[0].addr  <= pixel_number;
			for (int i = 1; i <= L; i++)
			begin
				tag_q[i] <= tag_q[i-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		fg_q[0] <= fg;
		for (int i = 1; i <= L; i++)
		begin
			fg_q[i] <= fg_q[i-1];
		end
	end

	// Read data is valid now for the slot at the end of the line
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out.tag <= '0;
		end
		else
		begin
			out.tag <= tag_q[L];
		end
	end

	always_ff @(posedge clk)
	begin
		out.fg <= fg_q[L];
		out.bg <= read_data;
	end

endmodule

`default_nettype wire

//--- src/blend_mac.sv
// Blend multiply-accumulate stage
// Forms alpha * fg + (255 - alpha) * bg for each channel
`timescale 1ns/1ps
`default_nettype none

module blend_mac (
	input  logic clk,
	input  logic rst_n,
	fetch_if.dst in,
	accum_if.src out
);

	// Weighted sum of one channel
	function automatic pixel_pkg::wsum_t weigh(
		input pixel_pkg::channel_t fg_c,
		input pixel_pkg::channel_t bg_c,
		input pixel_pkg::channel_t alpha
	);
		pixel_pkg::wsum_t fg_term;
		pixel_pkg::wsum_t bg_term;
		fg_term = pixel_pkg::wsum_t'(alpha) * pixel_pkg::wsum_t'(fg_c);
		bg_term = pixel_pkg::wsum_t'(8'd255 - alpha) * pixel_pkg::wsum_t'(bg_c);
		return fg_term + bg_term;
	endfunction

	pixel_pkg::wsum_rgb_t sum_d;

	always_comb
	begin
		sum_d.r = weigh(in.fg.rgb.r, in.bg.r, in.fg.a);
		sum_d.g = weigh(in.fg.rgb.g, in.bg.g, in.fg.a);
		sum_d.b = weigh(in.fg.rgb.b, in.bg.b, in.fg.a);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			out.tag <= '0;
		end
		else
		begin
			out.tag <= in.tag;
		end
	end

	// Sums hold across empty slots
	always_ff @(posedge clk)
	begin
		if (in.tag.valid)
		begin
			out.sum <= sum_d;
		end
	end

endmodule

`default_nettype wire

//--- src/pixel_writeback.sv
// Pixel writeback stage
// Scales the sums back to 8 bits and drives the frame-buffer write
// and the frame-ready pulse
`timescale 1ns/1ps
`default_nettype none

module pixel_writeback (
	input  logic                 clk,
	input  logic                 rst_n,
	accum_if.dst                 in,
	output logic                 write,
	output frame_pkg::pix_addr_t write_addr,
	output pixel_pkg::rgb_t      write_data,
	output logic                 o_frame_ready
);

	pixel_pkg::rgb_t blend_d;

	// Divide by 256 by keeping the high byte, no rounding
	always_comb
	begin
		blend_d.r = in.sum.r[15:8];
		blend_d.g = in.sum.g[15:8];
		blend_d.b = in.sum.b[15:8];
	end

	// One-cycle strobes, one slot per clock
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			write         <= 1'b0;
			o_frame_ready <= 1'b0;
		end
		else
		begin
			write         <= in.tag.valid;
			o_frame_ready <= in.tag.eof;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in.tag.valid)
		begin
			write_addr <= in.tag.addr;
			write_data <= blend_d;
		end
	end

endmodule

`default_nettype wire

//--- src/alpha_blender_top.sv
// Alpha blender top level
// Fetch, multiply-accumulate and writeback stages behind plain channel ports
`timescale 1ns/1ps
`default_nettype none

module alpha_blender_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 pixel_ready,
	input  frame_pkg::pix_addr_t pixel_number,
	input  pixel_pkg::channel_t  r,
	input  pixel_pkg::channel_t  g,
	input  pixel_pkg::channel_t  b,
	input  pixel_pkg::channel_t  a,
	input  logic                 frame_ready,
	output logic                 read,
	output frame_pkg::pix_addr_t read_addr,
	input  pixel_pkg::channel_t  read_r,
	input  pixel_pkg::channel_t  read_g,
	input  pixel_pkg::channel_t  read_b,
	output logic                 write,
	output frame_pkg::pix_addr_t write_addr,
	output pixel_pkg::channel_t  write_r,
	output pixel_pkg::channel_t  write_g,
	output pixel_pkg::channel_t  write_b,
	output logic                 o_frame_ready
);

	pixel_pkg::rgba_t fg_px;
	pixel_pkg::rgb_t  bg_px;
	pixel_pkg::rgb_t  wb_px;

	fetch_if f_link ();
	accum_if a_link ();

	// Pack external channels
	assign fg_px.rgb.r = r;
	assign fg_px.rgb.g = g;
	assign fg_px.rgb.b = b;
	assign fg_px.a     = a;
	assign bg_px.r     = read_r;
	assign bg_px.g     = read_g;
	assign bg_px.b     = read_b;

	pixel_fetch u_fetch (
		.clk          (clk),
		.rst_n        (rst_n),
		.pixel_ready  (pixel_ready),
		.pixel_number (pixel_number),
		.fg           (fg_px),
		.frame_ready  (frame_ready),
		.read         (read),
		.read_addr    (read_addr),
		.read_data    (bg_px),
		.out          (f_link)
	);

	blend_mac u_mac (
		.clk   (clk),
		.rst_n (rst_n),
		.in    (f_link),
		.out   (a_link)
	);

	pixel_writeback u_wb (
		.clk           (clk),
		.rst_n         (rst_n),
		.in            (a_link),
		.write         (write),
		.write_addr    (write_addr),
		.write_data    (wb_px),
		.o_frame_ready (o_frame_ready)
	);

	assign write_r = wb_px.r;
	assign write_g = wb_px.g;
	assign write_b = wb_px.b;

endmodule

`default_nettype wire

//--- verification/tb_alpha_blender.sv
// Alpha blender testbench
// Frame-buffer model, reference blend function and in-order write checks
`timescale 1ns/1ps
`default_nettype none

module tb_alpha_blender;

	localparam int FB_DEPTH   = 256;
	localparam int STREAM_LEN = 64;
	localparam int WAIT_LIMIT = 200;

	logic                 clk;
	logic                 rst_n;
	logic                 pixel_ready;
	frame_pkg::pix_addr_t pixel_number;
	pixel_pkg::channel_t  r;
	pixel_pkg::channel_t  g;
	pixel_pkg::channel_t  b;
	pixel_pkg::channel_t  a;
	logic                 frame_ready;
	logic                 read;
	frame_pkg::pix_addr_t read_addr;
	pixel_pkg::channel_t  read_r;
	pixel_pkg::channel_t  read_g;
	pixel_pkg::channel_t  read_b;
	logic                 write;
	frame_pkg::pix_addr_t write_addr;
	pixel_pkg::channel_t  write_r;
	pixel_pkg::channel_t  write_g;
	pixel_pkg::channel_t  write_b;
	logic                 o_frame_ready;

	// Frame buffer indexed by the low address byte
	logic [23:0]          mem [0:FB_DEPTH-1];
	logic [23:0]          rd_data = '0;
	logic                 pre_en;
	logic [7:0]           pre_addr;
	logic [23:0]          pre_data;

	frame_pkg::pix_addr_t rd_addr_q [$];
	frame_pkg::pix_addr_t exp_addr_q [$];
	logic [23:0]          exp_data_q [$];
	logic [31:0]          lcg_state = 32'h7245e361;
	int                   chk_errs = 0;
	int                   stim_errs = 0;
	int                   frame_cnt = 0;
	int                   tests = 0;

	alpha_blender_top u_dut (.*);

	assign read_r = rd_data[23:16];
	assign read_g = rd_data[15:8];
	assign read_b = rd_data[7:0];

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Expected channel with the low byte of the weighted sum dropped
	function automatic pixel_pkg::channel_t blend_channel(input pixel_pkg::channel_t fg_c,
		input pixel_pkg::channel_t bg_c, input pixel_pkg::channel_t alpha);
		int total;
		total = int'(alpha) * int'(fg_c) + (255 - int'(alpha)) * int'(bg_c);
		return pixel_pkg::channel_t'(total / 256);
	endfunction

	// Background pattern built from the whole index
	function automatic logic [23:0] fill_word(input logic [7:0] idx);
		return {idx ^ 8'h3c, ~idx, {idx[3:0], idx[7:4]}};
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int show_mismatch(input string name, input int expv, input int gotv);
		$display("mismatch at %0t: %s expected %0d got %0d", $time, name, expv, gotv);
		return 1;
	endfunction

	// Answers a read one cycle after sampling it and stores every write
	always @(posedge clk)
	begin
		int i;
		if (!rst_n)
		begin
			for (i = 0; i < FB_DEPTH; i++)
				mem[i] <= fill_word(8'(i));
			rd_data <= '0;
		end
		else
		begin
			if (pre_en)
				mem[pre_addr] <= pre_data;
			if (write)
				mem[write_addr[7:0]] <= {write_r, write_g, write_b};
			if (read)
				rd_data <= mem[read_addr[7:0]];
		end
	end

	// Reads and writes must come out in the order the pixels went in
	always @(negedge clk)
	begin
		frame_pkg::pix_addr_t e_addr;
		logic [23:0]          e_data;
		if (rst_n && read && rd_addr_q.size() == 0)
		begin
			$display("%0t: read from %h with no pixel pending", $time, read_addr);
			chk_errs++;
		end
		else if (rst_n && read)
		begin
			e_addr = rd_addr_q.pop_front();
			if (read_addr !== e_addr)
				chk_errs += show_mismatch("read_addr", int'(e_addr), int'(read_addr));
		end
		if (rst_n && write && exp_addr_q.size() == 0)
		begin
			$display("%0t: write to %h with no pixel pending", $time, write_addr);
			chk_errs++;
		end
		else if (rst_n && write)
		begin
			e_addr = exp_addr_q.pop_front();
			e_data = exp_data_q.pop_front();
			if (write_addr !== e_addr)
				chk_errs += show_mismatch("write_addr", int'(e_addr), int'(write_addr));
			if (write_r !== e_data[23:16])
				chk_errs += show_mismatch("write_r", int'(e_data[23:16]), int'(write_r));
			if (write_g !== e_data[15:8])
				chk_errs += show_mismatch("write_g", int'(e_data[15:8]), int'(write_g));
			if (write_b !== e_data[7:0])
				chk_errs += show_mismatch("write_b", int'(e_data[7:0]), int'(write_b));
		end
		if (rst_n && o_frame_ready)
		begin
			frame_cnt++;
			if (!write || exp_addr_q.size() != 0)
			begin
				$display("%0t: o_frame_ready did not come with the last write", $time);
				chk_errs++;
			end
		end
		else if (rst_n && write && frame_cnt != 0)
		begin
			$display("%0t: write seen after o_frame_ready", $time);
			chk_errs++;
		end
	end

	task automatic check_quiet();
		if ({read, write, o_frame_ready} !== 3'b000)
		begin
			$display("mismatch at %0t: {read,write,o_frame_ready} expected 000 got %b%b%b",
				$time, read, write, o_frame_ready);
			stim_errs++;
		end
	endtask

	task automatic send_pixel(input frame_pkg::pix_addr_t addr, input logic [31:0] rgba,
		input logic [23:0] bg, input logic eof);
		@(negedge clk);
		pixel_ready  = 1'b1;
		pixel_number = addr;
		r            = rgba[31:24];
		g            = rgba[23:16];
		b            = rgba[15:8];
		a            = rgba[7:0];
		frame_ready  = eof;
		rd_addr_q.push_back(addr);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back({blend_channel(rgba[31:24], bg[23:16], rgba[7:0]),
			blend_channel(rgba[23:16], bg[15:8], rgba[7:0]),
			blend_channel(rgba[15:8], bg[7:0], rgba[7:0])});
	endtask

	task automatic go_idle();
		@(negedge clk);
		pixel_ready = 1'b0;
		frame_ready = 1'b0;
	endtask

	task automatic preload(input logic [7:0] idx, input logic [23:0] data);
		@(negedge clk);
		pre_en   = 1'b1;
		pre_addr = idx;
		pre_data = data;
		@(negedge clk);
		pre_en   = 1'b0;
	endtask

	// Let the pipeline empty and then leave the frame buffer a few quiet cycles
	task automatic wait_writes();
		int n;
		for (n = 0; n < WAIT_LIMIT && exp_addr_q.size() != 0; n++)
			@(negedge clk);
		if (exp_addr_q.size() != 0)
		begin
			$display("%0t: timed out with %0d writes still missing", $time, exp_addr_q.size());
			stim_errs++;
		end
		if (rd_addr_q.size() != 0)
		begin
			$display("%0t: %0d reads were never issued", $time, rd_addr_q.size());
			stim_errs++;
			rd_addr_q.delete();
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("test %s: %s", name, (stim_errs + chk_errs == errs_before) ? "pass" : "fail");
	endtask

	initial
	begin
		int                   errs0;
		int                   n;
		int                   i;
		logic [31:0]          rnd;
		frame_pkg::pix_addr_t addr;
		logic [8:0]           recent [0:7];
		logic                 clash;
		rst_n        = 1'b0;
		pixel_ready  = 1'b0;
		pixel_number = '0;
		r            = '0;
		g            = '0;
		b            = '0;
		a            = '0;
		frame_ready  = 1'b0;
		pre_en       = 1'b0;
		pre_addr     = '0;
		pre_data     = '0;

		// Strobes stay low through 16 reset cycles and the idle time after
		errs0 = 0;
		for (n = 0; n < 24; n++)
		begin
			@(negedge clk);
			check_quiet();
			if (n == 15)
				rst_n = 1'b1;
		end
		report_test("reset", errs0);

		errs0 = stim_errs + chk_errs;
		preload(8'h10, 24'h010203);
		preload(8'hc1, 24'hffaa00);
		send_pixel(19'h00010, {8'd128, 8'd64, 8'd192, 8'd17}, 24'h010203, 1'b0);
		send_pixel(19'h4a3c1, 32'h0, 24'hffaa00, 1'b0);
		go_idle();
		wait_writes();
		if (mem[8'h10] !== 24'h09060f)
			stim_errs += show_mismatch("mem[0x10]", int'(24'h09060f), int'(mem[8'h10]));
		if (mem[8'hc1] !== 24'hfea900)
			stim_errs += show_mismatch("mem[0xc1]", int'(24'hfea900), int'(mem[8'hc1]));
		report_test("reference", errs0);

		errs0 = stim_errs + chk_errs;
		send_pixel(19'h12345, {8'd200, 8'd17, 8'd255, 8'd255}, mem[8'h45], 1'b0);
		send_pixel(19'h7ff80, {8'd9, 8'd99, 8'd250, 8'd0}, mem[8'h80], 1'b0);
		go_idle();
		wait_writes();
		report_test("extreme alpha", errs0);

		// Back to back pixels with the low address byte unique among the last eight
		errs0 = stim_errs + chk_errs;
		for (n = 0; n < 8; n++)
			recent[n] = 9'h100;
		for (i = 0; i < STREAM_LEN; i++)
		begin
			do
			begin
				rnd = lcg_next();
				addr = rnd[18:0];
				clash = 1'b0;
				for (n = 0; n < 8; n++)
					if (recent[n] == {1'b0, addr[7:0]})
						clash = 1'b1;
			end
			while (clash);
			recent[i[2:0]] = {1'b0, addr[7:0]};
			send_pixel(addr, lcg_next(), mem[addr[7:0]], 1'b0);
		end
		go_idle();
		wait_writes();
		report_test("streaming", errs0);

		// Marker rides with the last pixel of the burst
		errs0 = stim_errs + chk_errs;
		for (i = 0; i < 6; i++)
			send_pixel(19'h30000 + 19'(i), lcg_next(), mem[8'(i)], i == 5);
		go_idle();
		for (n = 0; n < WAIT_LIMIT && frame_cnt == 0; n++)
			@(negedge clk);
		repeat (8) @(negedge clk);
		if (frame_cnt != 1)
		begin
			$display("expected one o_frame_ready pulse within the wait, saw %0d", frame_cnt);
			stim_errs++;
		end
		wait_writes();
		report_test("frame marker", errs0);

		$display("%0d tests, %0d errors", tests, stim_errs + chk_errs);
		if (stim_errs + chk_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/pixel_pkg.sv
src/frame_pkg.sv
src/fetch_if.sv
src/accum_if.sv
src/pixel_fetch.sv
src/blend_mac.sv
src/pixel_writeback.sv
src/alpha_blender_top.sv
verification/tb_alpha_blender.sv

//--- run.sh
#!/bin/sh
# Build and run the alpha blender testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f flist.f \
	--top-module tb_alpha_blender -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Finished with errors" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"
